// File: source/lspPkg.sv
package lspPkg;

	////////////////////////////////////////
	// Widths
	////////////////////////////////////////

	// Scratch memory address and word width
	localparam int addrWidth = 12;
	localparam int dataWidth = 32;

	// One LSP coefficient, also used for gap
	localparam int lspWidth = 16;

	typedef logic signed [lspWidth-1:0] lspWord;
	typedef logic [dataWidth-1:0] memWord;
	typedef logic [addrWidth-1:0] memAddr;

	////////////////////////////////////////
	// Buffer layout
	////////////////////////////////////////

	// Address of buf[0], coefficient j at bufBase + j
	localparam memAddr bufBase = 12'd16;

	// Buffer length and first processed index
	localparam int lpcOrder = 10;
	localparam int firstIndex = 5;

	// Wide enough to hold lpcOrder - 1
	localparam int indexWidth = $clog2(lpcOrder);

	// Opcodes of the shared operator unit
	typedef enum logic [1:0]
	{
		opAdd,
		opSub,
		opShr
	} basicOp;

	// Sequencer states, one pass per index
	typedef enum logic [3:0]
	{
		sIdle,
		sReadLow,
		sReadHigh,
		sWaitData,
		sDiff,
		sTmp,
		sShift,
		sWriteLow,
		sWriteHigh,
		sDone
	} expandState;

endpackage

// File: source/memPortIf.sv
`timescale 1ns/100ps

// One read port and one write port into the scratch RAM
interface memPortIf;

	// Read side, data one cycle after address
	lspPkg::memAddr readAddr;
	lspPkg::memWord readData;

	// Write side, committed at the rising edge
	lspPkg::memAddr writeAddr;
	lspPkg::memWord writeData;
	logic writeEn;

	// Sequencer end
	modport master
	(
		output readAddr,
		input readData,
		output writeAddr,
		output writeData,
		output writeEn
	);

	// RAM end
	modport memory
	(
		input readAddr,
		output readData,
		input writeAddr,
		input writeData,
		input writeEn
	);

endinterface

// File: source/basicOps.sv
`timescale 1ns/100ps

// Saturating 16-bit add, sub and arithmetic shift right
module basicOps
(
	input lspPkg::basicOp opcode,
	input lspPkg::lspWord operandA,
	input lspPkg::lspWord operandB,
	output lspPkg::lspWord result
);

	// One extra bit to catch overflow
	logic signed [lspPkg::lspWidth:0] wideSum;
	logic signed [lspPkg::lspWidth:0] wideDiff;

	// Saturation limits
	localparam lspPkg::lspWord maxWord = 16'sh7FFF;
	localparam lspPkg::lspWord minWord = 16'sh8000;

	assign wideSum = {operandA[lspPkg::lspWidth-1], operandA}
		+ {operandB[lspPkg::lspWidth-1], operandB};
	assign wideDiff = {operandA[lspPkg::lspWidth-1], operandA}
		- {operandB[lspPkg::lspWidth-1], operandB};

	always_comb
	begin
		result = operandA;
		unique case (opcode)
			lspPkg::opAdd:
			begin
				// Top two bits differ on overflow
				if (wideSum[lspPkg::lspWidth] != wideSum[lspPkg::lspWidth-1])
					result = wideSum[lspPkg::lspWidth] ? minWord : maxWord;
				else
					result = wideSum[lspPkg::lspWidth-1:0];
			end
			lspPkg::opSub:
			begin
				if (wideDiff[lspPkg::lspWidth] != wideDiff[lspPkg::lspWidth-1])
					result = wideDiff[lspPkg::lspWidth] ? minWord : maxWord;
				else
					result = wideDiff[lspPkg::lspWidth-1:0];
			end
			lspPkg::opShr:
			begin
				// 15 or more leaves only the sign
				if (operandB >= 16'sd15)
					result = operandA >>> 15;
				// Negative count passes operandA through
				else if (operandB > 16'sd0)
					result = operandA >>> operandB[3:0];
			end
			default:
				result = operandA;
		endcase
	end

endmodule

// File: source/scratchMemory.sv
`timescale 1ns/100ps

// Scratch RAM shared by the sequencer and the test port
module scratchMemory
(
	input logic clk,
	memPortIf.memory mem,
	input logic testSel,
	input lspPkg::memAddr testReadAddr,
	input lspPkg::memAddr testWriteAddr,
	input lspPkg::memWord testWriteData,
	input logic testWriteEn,
	output lspPkg::memWord memData
);

	localparam int depth = 1 << lspPkg::addrWidth;

	lspPkg::memWord ram [depth];

	// Selected port
	lspPkg::memAddr readAddrSel;
	lspPkg::memAddr writeAddrSel;
	lspPkg::memWord writeDataSel;
	logic writeEnSel;

	lspPkg::memWord readReg;

	////////////////////////////////////////
	// Port select
	////////////////////////////////////////

	// Test port owns both sides when testSel is high
	always_comb
	begin
		if (testSel)
		begin
			readAddrSel = testReadAddr;
			writeAddrSel = testWriteAddr;
			writeDataSel = testWriteData;
			writeEnSel = testWriteEn;
		end
		else
		begin
			readAddrSel = mem.readAddr;
			writeAddrSel = mem.writeAddr;
			writeDataSel = mem.writeData;
			writeEnSel = mem.writeEn;
		end
	end

	////////////////////////////////////////
	// Array
	////////////////////////////////////////

	// Write at the edge, registered read
	always_ff @(posedge clk)
	begin
		if (writeEnSel)
			ram[writeAddrSel] <= writeDataSel;
		readReg <= ram[readAddrSel];
	end

	// Same read word to both owners
	assign mem.readData = readReg;
	assign memData = readReg;

endmodule

// File: source/lspExpand2Fsm.sv
`timescale 1ns/100ps

// Gap expansion over buf[4..9] by index
module lspExpand2Fsm
(
	input logic clk,
	input logic reset,
	input logic start,
	input lspPkg::lspWord gap,
	memPortIf.master mem,
	output lspPkg::basicOp opcode,
	output lspPkg::lspWord operandA,
	output lspPkg::lspWord operandB,
	input lspPkg::lspWord result,
	output logic done
);

	lspPkg::expandState state;
	lspPkg::expandState nextState;

	// Current j
	logic [lspPkg::indexWidth-1:0] index;

	// buf[j-1], buf[j], and the diff/tmp chain
	lspPkg::lspWord lowWord;
	lspPkg::lspWord highWord;
	lspPkg::lspWord tmpReg;

	lspPkg::memAddr lowAddr;
	lspPkg::memAddr highAddr;

	logic lastIndex;
	logic tmpPositive;
	logic indexDone;

	assign lowAddr = lspPkg::bufBase + lspPkg::memAddr'(index) - 12'd1;
	assign highAddr = lspPkg::bufBase + lspPkg::memAddr'(index);
	assign lastIndex = (index == lspPkg::indexWidth'(lspPkg::lpcOrder - 1));
	assign tmpPositive = (tmpReg > 16'sd0);

	// Leaving the current index with or without writes
	assign indexDone = (state == lspPkg::sWriteLow && !tmpPositive)
		|| (state == lspPkg::sWriteHigh);

	////////////////////////////////////////
	// State and index
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= lspPkg::sIdle;
			index <= '0;
		end
		else
		begin
			state <= nextState;
			// Fresh run starts at firstIndex
			if (state == lspPkg::sIdle && start)
				index <= lspPkg::indexWidth'(lspPkg::firstIndex);
			else if (indexDone)
				index <= index + 1'b1;
		end
	end

	always_comb
	begin
		nextState = state;
		unique case (state)
			lspPkg::sIdle: if (start) nextState = lspPkg::sReadLow;
			lspPkg::sReadLow: nextState = lspPkg::sReadHigh;
			lspPkg::sReadHigh: nextState = lspPkg::sWaitData;
			lspPkg::sWaitData: nextState = lspPkg::sDiff;
			lspPkg::sDiff: nextState = lspPkg::sTmp;
			lspPkg::sTmp: nextState = lspPkg::sShift;
			lspPkg::sShift: nextState = lspPkg::sWriteLow;
			lspPkg::sWriteLow:
			begin
				// tmp <= 0 skips both writes
				if (tmpPositive)
					nextState = lspPkg::sWriteHigh;
				else
					nextState = lastIndex ? lspPkg::sDone : lspPkg::sReadLow;
			end
			lspPkg::sWriteHigh:
				nextState = lastIndex ? lspPkg::sDone : lspPkg::sReadLow;
			lspPkg::sDone: nextState = lspPkg::sIdle;
			default: nextState = lspPkg::sIdle;
		endcase
	end

	////////////////////////////////////////
	// Datapath registers
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		unique case (state)
			// Data for buf[j-1] lands here
			lspPkg::sReadHigh: lowWord <= lspPkg::lspWord'(mem.readData[lspPkg::lspWidth-1:0]);
			lspPkg::sWaitData: highWord <= lspPkg::lspWord'(mem.readData[lspPkg::lspWidth-1:0]);
			// diff, then diff + gap, then tmp
			lspPkg::sDiff, lspPkg::sTmp, lspPkg::sShift: tmpReg <= result;
			// Updated high word kept
			lspPkg::sWriteHigh: highWord <= result;
			default: ;
		endcase
	end

	// Operator requests with the result used in the same cycle
	always_comb
	begin
		opcode = lspPkg::opAdd;
		operandA = '0;
		operandB = '0;
		unique case (state)
			lspPkg::sDiff:
			begin
				opcode = lspPkg::opSub;
				operandA = lowWord;
				operandB = highWord;
			end
			lspPkg::sTmp:
			begin
				opcode = lspPkg::opAdd;
				operandA = tmpReg;
				operandB = gap;
			end
			lspPkg::sShift:
			begin
				opcode = lspPkg::opShr;
				operandA = tmpReg;
				operandB = 16'sd1;
			end
			lspPkg::sWriteLow:
			begin
				opcode = lspPkg::opSub;
				operandA = lowWord;
				operandB = tmpReg;
			end
			lspPkg::sWriteHigh:
			begin
				opcode = lspPkg::opAdd;
				operandA = highWord;
				operandB = tmpReg;
			end
			default: ;
		endcase
	end

	////////////////////////////////////////
	// Memory port
	////////////////////////////////////////

	assign mem.readAddr = (state == lspPkg::sReadHigh) ? highAddr : lowAddr;
	assign mem.writeAddr = (state == lspPkg::sWriteHigh) ? highAddr : lowAddr;
	// Stored sign-extended
	assign mem.writeData = {{(lspPkg::dataWidth - lspPkg::lspWidth){result[lspPkg::lspWidth-1]}},
		result};
	assign mem.writeEn = (state == lspPkg::sWriteLow && tmpPositive)
		|| (state == lspPkg::sWriteHigh);

	// One cycle in sDone
	assign done = (state == lspPkg::sDone);

endmodule

// File: source/lspExpand2Pipe.sv
`timescale 1ns/100ps

// Gap expansion stage with its scratch RAM and test port
module lspExpand2Pipe
(
	input logic clk,
	input logic reset,
	input logic start,
	input logic testSel,
	input lspPkg::memAddr testReadAddr,
	input lspPkg::memAddr testWriteAddr,
	input lspPkg::memWord testWriteData,
	input logic testWriteEn,
	input lspPkg::lspWord gap,
	output lspPkg::memWord memData,
	output logic done
);

	// Sequencer to RAM
	memPortIf memPort();

	// Sequencer to operator unit
	lspPkg::basicOp opcode;
	lspPkg::lspWord operandA;
	lspPkg::lspWord operandB;
	lspPkg::lspWord result;

	lspExpand2Fsm u_lspExpand2Fsm
	(
		.clk(clk),
		.reset(reset),
		.start(start),
		.gap(gap),
		.mem(memPort.master),
		.opcode(opcode),
		.operandA(operandA),
		.operandB(operandB),
		.result(result),
		.done(done)
	);

	// Shared add, sub, shr
	basicOps u_basicOps
	(
		.opcode(opcode),
		.operandA(operandA),
		.operandB(operandB),
		.result(result)
	);

	// Test port muxes live inside
	scratchMemory u_scratchMemory
	(
		.clk(clk),
		.mem(memPort.memory),
		.testSel(testSel),
		.testReadAddr(testReadAddr),
		.testWriteAddr(testWriteAddr),
		.testWriteData(testWriteData),
		.testWriteEn(testWriteEn),
		.memData(memData)
	);

endmodule

// File: tests/clockGen.sv
`timescale 1ns/100ps

// Free-running testbench clock, 4 ns period
module clockGen
(
	output logic clk
);

	initial
	begin
		clk = 1'b0;
		// Half period of 2 ns
		forever #2 clk = ~clk;
	end

endmodule

// File: tests/lspExpand2_assert.sv
`timescale 1ns/100ps

// Protocol checks on the gap-expansion sequencer
module lspExpand2_assert
(
	input logic clk,
	input logic reset,
	input lspPkg::expandState state,
	input logic done,
	input logic writeEn,
	input lspPkg::memAddr writeAddr
);

	// Number of failed assertions so far
	int failCount = 0;

	// done is a single-cycle pulse
	doneOnePulse: assert property (@(posedge clk) disable iff (reset) done |=> !done)
		else
		begin
			$error("done held high for more than one cycle");
			failCount++;
		end

	// No writes while idle
	idleNoWrite: assert property (@(posedge clk) disable iff (reset)
		(state == lspPkg::sIdle) |-> !writeEn)
		else
		begin
			$error("write enable high in idle state");
			failCount++;
		end

	// Writes only touch buf[4..9]
	writeInBuffer: assert property (@(posedge clk) disable iff (reset)
		writeEn |-> (writeAddr >= lspPkg::bufBase + 12'd4)
			&& (writeAddr <= lspPkg::bufBase + 12'd9))
		else
		begin
			$error("write address outside buf[4..9]");
			failCount++;
		end

endmodule

bind lspExpand2Fsm lspExpand2_assert u_lspExpand2_assert
(
	.clk(clk),
	.reset(reset),
	.state(state),
	.done(done),
	.writeEn(mem.writeEn),
	.writeAddr(mem.writeAddr)
);

// File: tests/lspExpand2Tb.sv
`timescale 1ns/100ps

module lspExpand2Tb;

	// Watchdog budget
	localparam int numRuns = 30;
	localparam int cyclesPerRun = 200;
	localparam int clkPeriod = 4;

	logic clk;
	logic reset;
	logic start;
	logic testSel;
	lspPkg::memAddr testReadAddr;
	lspPkg::memAddr testWriteAddr;
	lspPkg::memWord testWriteData;
	logic testWriteEn;
	lspPkg::lspWord gap;
	lspPkg::memWord memData;
	logic done;

	int errorCount;

	// Buffer loaded into the RAM and the buffer the model predicts
	lspPkg::lspWord initialBuf [lspPkg::lpcOrder];
	lspPkg::lspWord expectBuf [lspPkg::lpcOrder];

	clockGen u_clockGen
	(
		.clk(clk)
	);

	lspExpand2Pipe u_lspExpand2Pipe
	(
		.clk(clk),
		.reset(reset),
		.start(start),
		.testSel(testSel),
		.testReadAddr(testReadAddr),
		.testWriteAddr(testWriteAddr),
		.testWriteData(testWriteData),
		.testWriteEn(testWriteEn),
		.gap(gap),
		.memData(memData),
		.done(done)
	);

	////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////

	task automatic checkWord(input string name, input lspPkg::memWord expected,
		input lspPkg::memWord actual);
		if (actual !== expected)
		begin
			errorCount++;
			$display("mismatch at %0t: %s expected %h got %h", $time, name, expected, actual);
		end
	endtask

	task automatic checkDone(input string name, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			errorCount++;
			$display("mismatch at %0t: %s expected %b got %b", $time, name, expected, actual);
		end
	endtask

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	// Saturate to the 16-bit signed range
	function automatic lspPkg::lspWord clampWord(input int value);
		if (value > 32767)
			return 16'sh7FFF;
		if (value < -32768)
			return 16'sh8000;
		return lspPkg::lspWord'(value);
	endfunction

	// Coefficients are stored sign-extended
	function automatic lspPkg::memWord widenWord(input lspPkg::lspWord w);
		return {{16{w[15]}}, w};
	endfunction

	task automatic expandModel(input lspPkg::lspWord g);
		lspPkg::lspWord diff;
		lspPkg::lspWord tmp;
		int j;
		for (j = 0; j < lspPkg::lpcOrder; j++)
			expectBuf[j] = initialBuf[j];
		// Each index sees the previous index's update
		for (j = lspPkg::firstIndex; j < lspPkg::lpcOrder; j++)
		begin
			diff = clampWord(int'(expectBuf[j-1]) - int'(expectBuf[j]));
			tmp = clampWord(int'(diff) + int'(g));
			tmp = tmp >>> 1;
			if (tmp > 16'sd0)
			begin
				expectBuf[j-1] = clampWord(int'(expectBuf[j-1]) - int'(tmp));
				expectBuf[j] = clampWord(int'(expectBuf[j]) + int'(tmp));
			end
		end
	endtask

	////////////////////////////////////////
	// Bus tasks entered and left on a falling edge
	////////////////////////////////////////

	task automatic writeWord(input lspPkg::memAddr addr, input lspPkg::memWord data);
		testSel = 1'b1;
		testWriteAddr = addr;
		testWriteData = data;
		testWriteEn = 1'b1;
		@(negedge clk);
		testWriteEn = 1'b0;
	endtask

	// Registered read with data one cycle later
	task automatic readWord(input lspPkg::memAddr addr, output lspPkg::memWord data);
		testSel = 1'b1;
		testReadAddr = addr;
		@(negedge clk);
		data = memData;
	endtask

	task automatic loadBuffer;
		int i;
		for (i = 0; i < lspPkg::lpcOrder; i++)
			writeWord(lspPkg::memAddr'(lspPkg::bufBase + i), widenWord(initialBuf[i]));
	endtask

	task automatic checkBuffer;
		lspPkg::memWord word;
		int i;
		for (i = 0; i < lspPkg::lpcOrder; i++)
		begin
			readWord(lspPkg::memAddr'(lspPkg::bufBase + i), word);
			checkWord($sformatf("buf[%0d]", i), widenWord(expectBuf[i]), word);
		end
	endtask

	// Start pulse, optional second pulse mid-run, then wait for done
	task automatic runExpansion(input lspPkg::lspWord g, input bit restart);
		testSel = 1'b0;
		gap = g;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		if (restart)
		begin
			repeat (10) @(negedge clk);
			start = 1'b1;
			@(negedge clk);
			start = 1'b0;
		end
		while (done !== 1'b1)
			@(negedge clk);
		@(negedge clk);
		checkDone("done", 1'b0, done);
		testSel = 1'b1;
	endtask

	task automatic runAndCheck(input lspPkg::lspWord g);
		loadBuffer();
		expandModel(g);
		runExpansion(g, 1'b0);
		checkBuffer();
	endtask

	task automatic randomBuffer;
		int i;
		for (i = 0; i < lspPkg::lpcOrder; i++)
			initialBuf[i] = lspPkg::lspWord'($urandom);
	endtask

	////////////////////////////////////////
	// Watchdog
	////////////////////////////////////////

	initial
	begin
		#(numRuns * cyclesPerRun * clkPeriod);
		errorCount++;
		$display("timeout waiting for done");
		$display("errors: %0d, assertion failures: %0d", errorCount,
			u_lspExpand2Pipe.u_lspExpand2Fsm.u_lspExpand2_assert.failCount);
		$display("Errors found");
		$finish;
	end

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////

	initial
	begin
		lspPkg::memAddr addr;
		lspPkg::memWord data;
		lspPkg::memWord word;
		lspPkg::lspWord g;
		int k;
		int assertFails;

		void'($urandom(96319));
		errorCount = 0;
		reset = 1'b1;
		start = 1'b0;
		testSel = 1'b1;
		testReadAddr = '0;
		testWriteAddr = '0;
		testWriteData = '0;
		testWriteEn = 1'b0;
		gap = '0;

		repeat (8) @(negedge clk);
		reset = 1'b0;

		// Idle after reset
		repeat (20)
		begin
			@(negedge clk);
			checkDone("done", 1'b0, done);
		end

		// Test port write then read over both ends of the address range
		for (k = 0; k < 10; k++)
		begin
			if (k == 0)
				addr = '0;
			else if (k == 1)
				addr = 12'hFFF;
			else
				addr = lspPkg::memAddr'($urandom % 4096);
			data = $urandom;
			writeWord(addr, data);
			readWord(addr, word);
			checkWord("memData", data, word);
		end

		// Random buffers and a random positive gap
		for (k = 0; k < 20; k++)
		begin
			randomBuffer();
			g = lspPkg::lspWord'(1 + $urandom % 16384);
			runAndCheck(g);
		end

		// Alternating extremes with a large gap
		for (k = 0; k < lspPkg::lpcOrder; k++)
			initialBuf[k] = (k % 2) ? 16'sh8001 : 16'sh7FFF;
		runAndCheck(16'sd32000);
		for (k = 0; k < lspPkg::lpcOrder; k++)
			initialBuf[k] = (k < lspPkg::firstIndex) ? 16'sh7FFF : 16'sh8000;
		runAndCheck(16'sh7FFF);

		// Sorted and widely spaced so tmp is never positive
		for (k = 0; k < lspPkg::lpcOrder; k++)
			initialBuf[k] = lspPkg::lspWord'(-20000 + k * 4000);
		runAndCheck(16'sd100);

		// Second start mid-run is ignored
		randomBuffer();
		g = lspPkg::lspWord'(1 + $urandom % 16384);
		loadBuffer();
		expandModel(g);
		runExpansion(g, 1'b1);
		checkBuffer();
		repeat (60)
		begin
			@(negedge clk);
			checkDone("done", 1'b0, done);
		end

		// Back-to-back run on the updated buffer
		for (k = 0; k < lspPkg::lpcOrder; k++)
			initialBuf[k] = expectBuf[k];
		g = lspPkg::lspWord'(1 + $urandom % 16384);
		expandModel(g);
		runExpansion(g, 1'b0);
		checkBuffer();

		assertFails = u_lspExpand2Pipe.u_lspExpand2Fsm.u_lspExpand2_assert.failCount;
		$display("errors: %0d, assertion failures: %0d", errorCount, assertFails);
		if (errorCount == 0 && assertFails == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// File: tb.f
source/lspPkg.sv
source/memPortIf.sv
source/basicOps.sv
source/scratchMemory.sv
source/lspExpand2Fsm.sv
source/lspExpand2Pipe.sv
tests/clockGen.sv
tests/lspExpand2_assert.sv
tests/lspExpand2Tb.sv

// File: Bender.yml
package:
  name: lspExpand2

sources:
  - source/lspPkg.sv
  - source/memPortIf.sv
  - source/basicOps.sv
  - source/scratchMemory.sv
  - source/lspExpand2Fsm.sv
  - source/lspExpand2Pipe.sv
  - target: test
    files:
      - tests/clockGen.sv
      - tests/lspExpand2_assert.sv
      - tests/lspExpand2Tb.sv
